/* build.f */
+incdir+src
src/cam_pkg.sv
src/camera_capture.sv
src/frame_buffer.sv
src/display_reader.sv
src/cam_regs.sv
src/camera_top.sv
bench/tb_clock_gen.sv
bench/camera_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    = --binary --timing -Wno-fatal -j 0
TOP       = camera_tb
FILELIST  = build.f
OBJ_DIR   = obj_dir
PASS_MSG  = Everything OK

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build products"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* bench/camera_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cam_config.svh"

module camera_tb;
    import cam_pkg::*;

    localparam int SCAN_W = 32;
    localparam int SCAN_H = 16;
    localparam int PART_H = 8;                      // Short scan ends inside the window

    typedef struct packed {
        logic signed [`CAM_POS_W-1:0] x;
        logic signed [`CAM_POS_W-1:0] y;
        logic signed [`CAM_POS_W-1:0] xs;           // Window origin at scan time
        logic signed [`CAM_POS_W-1:0] ys;
        t_rgb                         rgb;
    } t_sample;

    logic        clk;
    logic        rst;
    t_cam_in     cam;
    t_raster     raster;
    t_wb_req     wb_req;
    t_wb_rsp     wb_rsp;
    t_rgb        rgb;
    logic [15:0] model [`CAM_FB_PIXELS];            // Mirror of the captured frame
    logic [15:0] lfsr = 16'd20773;
    t_sample     sample_q [$];
    int          reg_checks = 0;
    int          reg_errs = 0;
    int          pix_checks = 0;
    int          in_errs = 0;
    int          out_errs = 0;

    tb_clock_gen u_clock_gen (
        .o_clk (clk),
        .o_rst (rst)
    );

    camera_top dut (
        .i_clk    (clk),
        .i_rst    (rst),
        .i_cam    (cam),
        .i_raster (raster),
        .i_wb     (wb_req),
        .o_wb     (wb_rsp),
        .o_rgb    (rgb)
    );

    function automatic logic in_window(input int x, input int y, input int xs, input int ys);
        return (x >= xs) && (x < xs + `CAM_FB_WIDTH) && (y >= ys) && (y < ys + `CAM_FB_HEIGHT);
    endfunction

    // Expected display pixel for one raster position
    function automatic t_rgb expected_rgb(input int x, input int y, input int xs, input int ys);
        logic [15:0] px;
        t_rgb        exp;
        exp = '0;
        if (in_window(x, y, xs, ys)) begin
            px    = model[(y - ys) * `CAM_FB_WIDTH + (x - xs)];
            exp.r = {px[15:11], 3'b000};
            exp.g = {px[10:5], 2'b00};
            exp.b = {px[4:0], 3'b000};
        end
        return exp;
    endfunction

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);  // Galois taps 16,14,13,11
    endfunction

    task automatic random_pixel(output logic [15:0] px);
        px = '0;
        for (int i = 0; i < 16; i++) begin
            lfsr = lfsr_next(lfsr);
            px   = {px[14:0], lfsr[0]};             // One step per bit
        end
    endtask

    task automatic abort_run(input string why);
        $display("run stopped: %s", why);
        $display("Something failed");
        $finish;
    endtask

    task automatic wb_access(input logic we, input logic [1:0] adr, input logic [31:0] wdat,
                             output logic [31:0] rdat);
        int n;
        @(negedge clk);
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
        for (n = 0; n < 50 && !wb_rsp.ack; n++) begin
            @(negedge clk);
        end
        rdat   = wb_rsp.dat;
        wb_req = '0;                                // End of bus cycle
        if (!wb_rsp.ack) begin
            abort_run("no Wishbone ack within 50 cycles");
        end
    endtask

    task automatic wb_write(input logic [1:0] adr, input logic [31:0] dat);
        logic [31:0] ignored;
        wb_access(1'b1, adr, dat, ignored);
    endtask

    task automatic read_check(input logic [1:0] adr, input logic [31:0] exp, input string what);
        logic [31:0] got;
        wb_access(1'b0, adr, 32'd0, got);
        reg_checks++;
        if (got !== exp) begin
            reg_errs++;
            $display("mismatch at %0t: %s read %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic cam_cycle(input logic vs, input logic hr, input logic pc, input logic [7:0] d);
        @(negedge clk);
        cam = '{vsync: vs, href: hr, pclk: pc, data: d};
    endtask

    task automatic vsync_pulse();
        for (int i = 0; i < 6; i++) begin
            cam_cycle(i < 3, 1'b0, 1'b0, 8'h00);
        end
    endtask

    task automatic send_frame(input logic keep);
        logic [15:0] px;
        vsync_pulse();
        for (int row = 0; row < `CAM_FB_HEIGHT; row++) begin
            cam_cycle(1'b0, 1'b1, 1'b0, 8'h00);     // Line opens before data
            for (int col = 0; col < `CAM_FB_WIDTH; col++) begin
                random_pixel(px);
                if (keep) begin
                    model[row * `CAM_FB_WIDTH + col] = px;
                end
                cam_cycle(1'b0, 1'b1, 1'b1, px[15:8]);  // High byte first
                cam_cycle(1'b0, 1'b1, 1'b0, 8'h00);
                cam_cycle(1'b0, 1'b1, 1'b1, px[7:0]);
                cam_cycle(1'b0, 1'b1, 1'b0, 8'h00);
            end
            repeat (3) cam_cycle(1'b0, 1'b0, 1'b0, 8'h00);
        end
        vsync_pulse();
    endtask

    // Outputs lag their raster position by two cycles
    task automatic scan_raster(input int xs, input int ys, input int rows);
        t_sample s;
        int      k;
        @(negedge clk);
        raster = '{frame: 1'b1, line: 1'b0, x: -16'sd1, y: -16'sd1};
        for (k = 0; k < rows * SCAN_W + 2; k++) begin
            @(negedge clk);
            if (k >= 2) begin
                s.x   = 16'((k - 2) % SCAN_W);
                s.y   = 16'((k - 2) / SCAN_W);
                s.xs  = 16'(xs);
                s.ys  = 16'(ys);
                s.rgb = rgb;
                sample_q.push_back(s);
            end
            if (k < rows * SCAN_W) begin
                raster = '{frame: 1'b0, line: (k % SCAN_W) == 0,
                           x: 16'(k % SCAN_W), y: 16'(k / SCAN_W)};
            end else begin
                raster = '{frame: 1'b0, line: 1'b0, x: -16'sd1, y: -16'sd1};
            end
        end
    endtask

    task automatic wait_drain();
        int n;
        for (n = 0; n < 100 && sample_q.size() > 0; n++) begin
            @(negedge clk);
        end
        if (sample_q.size() > 0) begin
            abort_run("pixel checker did not empty its queue");
        end
    endtask

    task automatic report_test(input int num, input string name, input int errs);
        $display("test %0d %s: %s, %0d errors", num, name, (errs == 0) ? "pass" : "FAIL", errs);
    endtask

    always @(negedge clk) begin : compare_samples
        t_sample s;
        t_rgb    exp;
        if (sample_q.size() > 0) begin
            s   = sample_q.pop_front();
            exp = expected_rgb(s.x, s.y, s.xs, s.ys);
            pix_checks++;
            if (s.rgb !== exp) begin
                if (in_window(s.x, s.y, s.xs, s.ys)) begin
                    in_errs++;
                end else begin
                    out_errs++;
                end
                $display("mismatch at %0t: pixel (%0d,%0d) got %h expected %h",
                         $time, s.x, s.y, s.rgb, exp);
            end
        end
    end

    initial begin : run_tests
        int n;
        int base;
        int base_in;
        int base_out;
        cam    = '0;
        raster = '{frame: 1'b0, line: 1'b0, x: -16'sd1, y: -16'sd1};
        wb_req = '0;
        for (n = 0; n < 20 && rst !== 1'b0; n++) begin
            @(negedge clk);
        end
        if (rst !== 1'b0) begin
            abort_run("reset was never released");
        end

        base = reg_errs;
        read_check(`CAM_REG_CTRL, 32'd0, "CTRL after reset");
        read_check(`CAM_REG_XSTART, `CAM_X_START_RST, "X_START after reset");
        read_check(`CAM_REG_YSTART, `CAM_Y_START_RST, "Y_START after reset");
        read_check(`CAM_REG_FRAMES, 32'd0, "FRAMES after reset");
        wb_write(`CAM_REG_XSTART, 32'd7);
        read_check(`CAM_REG_XSTART, 32'd7, "X_START readback");
        wb_write(`CAM_REG_YSTART, 32'd3);
        read_check(`CAM_REG_YSTART, 32'd3, "Y_START readback");
        wb_write(`CAM_REG_FRAMES, 32'd99);
        read_check(`CAM_REG_FRAMES, 32'd0, "FRAMES after write");
        wb_write(`CAM_REG_XSTART, 32'd4);
        wb_write(`CAM_REG_YSTART, 32'd2);
        report_test(1, "register reset and access", reg_errs - base);

        wb_write(`CAM_REG_CTRL, 32'd1);
        send_frame(1'b1);
        base_in  = in_errs;
        base_out = out_errs;
        scan_raster(4, 2, SCAN_H);
        wait_drain();
        report_test(2, "captured frame in window", in_errs - base_in);
        report_test(3, "black outside window", out_errs - base_out);

        wb_write(`CAM_REG_CTRL, 32'd0);
        send_frame(1'b0);                           // Model keeps the first frame
        base = in_errs + out_errs;
        scan_raster(4, 2, SCAN_H);
        wait_drain();
        report_test(4, "frame skipped while disabled", in_errs + out_errs - base);

        base = reg_errs;
        read_check(`CAM_REG_FRAMES, 32'd1, "FRAMES after two frames");
        report_test(5, "captured frame count", reg_errs - base);

        wb_write(`CAM_REG_XSTART, 32'd10);
        wb_write(`CAM_REG_YSTART, 32'd5);
        base = in_errs + out_errs;
        scan_raster(10, 5, PART_H);                 // Read address left mid frame
        scan_raster(10, 5, SCAN_H);
        wait_drain();
        report_test(6, "moved window origin", in_errs + out_errs - base);

        if (pix_checks != 3 * SCAN_W * SCAN_H + PART_H * SCAN_W) begin
            reg_errs++;
            $display("pixel checker saw %0d samples instead of %0d",
                     pix_checks, 3 * SCAN_W * SCAN_H + PART_H * SCAN_W);
        end
        $display("checks %0d, errors %0d", reg_checks + pix_checks,
                 reg_errs + in_errs + out_errs);
        if (reg_errs + in_errs + out_errs == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* bench/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic o_clk,
    output logic o_rst
);

    localparam real HALF_PERIOD = 4.0;              // 8 ns clock

    initial begin
        o_clk = 1'b0;
        forever #(HALF_PERIOD) o_clk = ~o_clk;
    end

    initial begin
        o_rst = 1'b1;
        repeat (5) @(posedge o_clk);                // Five reset edges
        @(negedge o_clk);
        o_rst = 1'b0;
    end

endmodule

`default_nettype wire

/* src/camera_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cam_config.svh"

module camera_top (
    input  logic             i_clk,
    input  logic             i_rst,
    input  cam_pkg::t_cam_in i_cam,
    input  cam_pkg::t_raster i_raster,
    input  cam_pkg::t_wb_req i_wb,
    output cam_pkg::t_wb_rsp o_wb,
    output cam_pkg::t_rgb    o_rgb
);
    import cam_pkg::*;

    t_fb_wr                       fb_wr;        // Capture to frame buffer
    logic                         rd_en;
    logic [`CAM_FB_ADDRW-1:0]     rd_addr;
    logic [15:0]                  rd_data;
    logic                         capture_en;
    logic                         frame_done;
    logic signed [`CAM_POS_W-1:0] x_start;
    logic signed [`CAM_POS_W-1:0] y_start;

    camera_capture u_capture (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_cam        (i_cam),
        .i_enable     (capture_en),
        .o_fb_wr      (fb_wr),
        .o_frame_done (frame_done)
    );

    frame_buffer u_frame_buffer (
        .i_clk     (i_clk),
        .i_wr      (fb_wr),
        .i_rd_en   (rd_en),
        .i_rd_addr (rd_addr),
        .o_rd_data (rd_data)
    );

    display_reader u_reader (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_raster  (i_raster),
        .i_x_start (x_start),
        .i_y_start (y_start),
        .i_rd_data (rd_data),
        .o_rd_en   (rd_en),
        .o_rd_addr (rd_addr),
        .o_rgb     (o_rgb)
    );

    cam_regs u_regs (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_wb         (i_wb),
        .o_wb         (o_wb),
        .i_frame_done (frame_done),
        .o_capture_en (capture_en),
        .o_x_start    (x_start),
        .o_y_start    (y_start)
    );

endmodule

`default_nettype wire

/* src/cam_regs.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cam_config.svh"

module cam_regs (
    input  logic                         i_clk,
    input  logic                         i_rst,
    input  cam_pkg::t_wb_req             i_wb,
    output cam_pkg::t_wb_rsp             o_wb,
    input  logic                         i_frame_done,
    output logic                         o_capture_en,
    output logic signed [`CAM_POS_W-1:0] o_x_start,
    output logic signed [`CAM_POS_W-1:0] o_y_start
);

    localparam logic signed [`CAM_POS_W-1:0] X_RST = `CAM_X_START_RST;
    localparam logic signed [`CAM_POS_W-1:0] Y_RST = `CAM_Y_START_RST;
    localparam int EXT_W = 32 - `CAM_POS_W;

    logic        ack_q;
    logic [31:0] rdata_q;
    logic [31:0] frames_q;
    logic        access;                        // New cycle, not yet acked

    assign access = i_wb.cyc & i_wb.stb & ~ack_q;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            ack_q        <= 1'b0;
            o_capture_en <= 1'b0;
            o_x_start    <= X_RST;
            o_y_start    <= Y_RST;
            frames_q     <= '0;
        end else begin
            ack_q <= access;                    // Single cycle ack
            if (access && i_wb.we) begin
                case (i_wb.adr)
                    `CAM_REG_CTRL:   o_capture_en <= i_wb.dat[0];
                    `CAM_REG_XSTART: o_x_start    <= i_wb.dat[`CAM_POS_W-1:0];
                    `CAM_REG_YSTART: o_y_start    <= i_wb.dat[`CAM_POS_W-1:0];
                    default:         o_capture_en <= o_capture_en;  // FRAMES read only
                endcase
            end
            if (i_frame_done) begin
                frames_q <= frames_q + 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (access) begin
            case (i_wb.adr)
                `CAM_REG_CTRL:   rdata_q <= {31'd0, o_capture_en};
                `CAM_REG_XSTART: rdata_q <= {{EXT_W{o_x_start[`CAM_POS_W-1]}}, o_x_start};
                `CAM_REG_YSTART: rdata_q <= {{EXT_W{o_y_start[`CAM_POS_W-1]}}, o_y_start};
                `CAM_REG_FRAMES: rdata_q <= frames_q;
                default:         rdata_q <= '0;
            endcase
        end
    end

    assign o_wb = '{ack: ack_q, dat: rdata_q};

endmodule

`default_nettype wire

/* src/display_reader.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cam_config.svh"

module display_reader (
    input  logic                         i_clk,
    input  logic                         i_rst,
    input  cam_pkg::t_raster             i_raster,
    input  logic signed [`CAM_POS_W-1:0] i_x_start,
    input  logic signed [`CAM_POS_W-1:0] i_y_start,
    input  logic [15:0]                  i_rd_data,
    output logic                         o_rd_en,
    output logic [`CAM_FB_ADDRW-1:0]     o_rd_addr,
    output cam_pkg::t_rgb                o_rgb
);

    localparam logic signed [`CAM_POS_W-1:0] FB_W = `CAM_FB_WIDTH;
    localparam logic signed [`CAM_POS_W-1:0] FB_H = `CAM_FB_HEIGHT;

    logic                     x_in;
    logic                     y_in;
    logic                     inside_q;         // Position inside window, t+1
    logic                     draw_q;           // Aligned with RAM data, t+2
    logic [`CAM_FB_ADDRW-1:0] rd_addr_q;

    assign x_in = (i_raster.x >= i_x_start) && (i_raster.x < i_x_start + FB_W);
    assign y_in = (i_raster.y >= i_y_start) && (i_raster.y < i_y_start + FB_H);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            inside_q  <= 1'b0;
            draw_q    <= 1'b0;
            rd_addr_q <= '0;
        end else begin
            inside_q <= x_in & y_in;
            draw_q   <= inside_q;
            if (i_raster.frame) begin
                rd_addr_q <= '0;                // Restart at first pixel
            end else if (inside_q) begin
                rd_addr_q <= rd_addr_q + 1'b1;  // Next pixel after this read
            end
        end
    end

    assign o_rd_en   = inside_q;
    assign o_rd_addr = rd_addr_q;

    // RGB565 to RGB888, low bits zero, black outside the window
    always_comb begin
        o_rgb = '0;
        if (draw_q) begin
            o_rgb.r = {i_rd_data[15:11], 3'b000};
            o_rgb.g = {i_rd_data[10:5], 2'b00};
            o_rgb.b = {i_rd_data[4:0], 3'b000};
        end
    end

endmodule

`default_nettype wire

/* src/frame_buffer.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cam_config.svh"

module frame_buffer (
    input  logic                     i_clk,
    input  cam_pkg::t_fb_wr          i_wr,
    input  logic                     i_rd_en,
    input  logic [`CAM_FB_ADDRW-1:0] i_rd_addr,
    output logic [15:0]              o_rd_data
);

    logic [15:0] mem [`CAM_FB_PIXELS];          // RGB565 pixels, row major

    always_ff @(posedge i_clk) begin
        if (i_wr.we) begin
            mem[i_wr.addr] <= i_wr.data;
        end
    end

    // Output register holds the last read while idle
    always_ff @(posedge i_clk) begin
        if (i_rd_en) begin
            o_rd_data <= mem[i_rd_addr];
        end
    end

endmodule

`default_nettype wire

/* src/camera_capture.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cam_config.svh"

module camera_capture (
    input  logic             i_clk,
    input  logic             i_rst,
    input  cam_pkg::t_cam_in i_cam,
    input  logic             i_enable,
    output cam_pkg::t_fb_wr  o_fb_wr,
    output logic             o_frame_done
);
    import cam_pkg::*;

    localparam logic [`CAM_POS_W-1:0] FB_W = `CAM_FB_WIDTH;
    localparam logic [`CAM_POS_W-1:0] FB_H = `CAM_FB_HEIGHT;

    t_cap_state               state_q;
    logic                     vsync_q;
    logic                     href_q;
    logic [`CAM_POS_W-1:0]    row_q;
    logic [`CAM_POS_W-1:0]    col_q;
    logic                     wrote_q;          // Frame had at least one write
    logic [7:0]               hi_byte_q;
    logic                     wr_en_q;
    logic [`CAM_FB_ADDRW-1:0] wr_addr_q;
    logic [15:0]              wr_data_q;
    logic                     vsync_rise;
    logic                     href_fall;
    logic                     byte_ok;
    logic                     in_fb;
    logic [`CAM_POS_W-1:0]    lin_addr;

    assign vsync_rise = i_cam.vsync & ~vsync_q;
    assign href_fall  = href_q & ~i_cam.href;
    assign byte_ok    = i_cam.pclk & i_cam.href;
    assign in_fb      = (row_q < FB_H) && (col_q < FB_W);  // Clip to buffer size
    assign lin_addr   = row_q * FB_W + col_q;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state_q      <= CAP_IDLE;
            vsync_q      <= 1'b0;
            href_q       <= 1'b0;
            row_q        <= '0;
            col_q        <= '0;
            wrote_q      <= 1'b0;
            wr_en_q      <= 1'b0;
            o_frame_done <= 1'b0;
        end else begin
            vsync_q      <= i_cam.vsync;
            href_q       <= i_cam.href;
            wr_en_q      <= 1'b0;
            o_frame_done <= 1'b0;
            if (vsync_rise) begin
                row_q        <= '0;
                col_q        <= '0;
                o_frame_done <= wrote_q;        // Previous frame finished
                wrote_q      <= 1'b0;
                state_q      <= i_enable ? CAP_WAIT_LINE : CAP_IDLE;
            end else if (href_fall) begin
                col_q <= '0;
                if (row_q < FB_H) begin
                    row_q <= row_q + 1'b1;      // Saturates past last row
                end
                if (state_q != CAP_IDLE) begin
                    state_q <= CAP_WAIT_LINE;
                end
            end else if (byte_ok) begin
                case (state_q)
                    CAP_IDLE:      state_q <= CAP_IDLE;
                    CAP_WAIT_LINE: state_q <= CAP_LOW;
                    CAP_HIGH:      state_q <= CAP_LOW;
                    CAP_LOW: begin
                        state_q <= CAP_HIGH;
                        wr_en_q <= in_fb;
                        wrote_q <= wrote_q | in_fb;
                        if (col_q < FB_W) begin
                            col_q <= col_q + 1'b1;
                        end
                    end
                    default:       state_q <= CAP_IDLE;
                endcase
            end
        end
    end

    // Pixel payload, qualified by wr_en_q
    always_ff @(posedge i_clk) begin
        if (byte_ok) begin
            if (state_q == CAP_LOW) begin
                wr_addr_q <= lin_addr[`CAM_FB_ADDRW-1:0];
                wr_data_q <= {hi_byte_q, i_cam.data};
            end else begin
                hi_byte_q <= i_cam.data;        // First byte of the pair
            end
        end
    end

    assign o_fb_wr = '{we: wr_en_q, addr: wr_addr_q, data: wr_data_q};

endmodule

`default_nettype wire

/* src/cam_pkg.sv */
`default_nettype none
`include "cam_config.svh"

package cam_pkg;

    typedef struct packed {
        logic       vsync;
        logic       href;
        logic       pclk;                       // Byte strobe in i_clk domain
        logic [7:0] data;
    } t_cam_in;

    typedef struct packed {
        logic                         frame;    // Start of display frame
        logic                         line;     // Start of display line
        logic signed [`CAM_POS_W-1:0] x;
        logic signed [`CAM_POS_W-1:0] y;
    } t_raster;

    typedef struct packed {
        logic                     we;
        logic [`CAM_FB_ADDRW-1:0] addr;
        logic [15:0]              data;         // RGB565
    } t_fb_wr;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } t_rgb;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [1:0]  adr;                       // Word address
        logic [31:0] dat;
    } t_wb_req;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } t_wb_rsp;

    typedef enum logic [1:0] {
        CAP_IDLE,                               // Frame skipped or not started
        CAP_WAIT_LINE,
        CAP_HIGH,
        CAP_LOW
    } t_cap_state;

endpackage

`default_nettype wire

/* src/cam_config.svh */
`ifndef CAM_CONFIG_SVH
`define CAM_CONFIG_SVH

// Frame buffer geometry, one RGB565 word per pixel
`define CAM_FB_WIDTH    16
`define CAM_FB_HEIGHT   8
`define CAM_FB_PIXELS   (`CAM_FB_WIDTH * `CAM_FB_HEIGHT)
`define CAM_FB_ADDRW    7

// Signed raster coordinates from the display timing
`define CAM_POS_W       16

// Window origin after reset
`define CAM_X_START_RST 4
`define CAM_Y_START_RST 2

// Wishbone word addresses
`define CAM_REG_CTRL    2'd0
`define CAM_REG_XSTART  2'd1
`define CAM_REG_YSTART  2'd2
`define CAM_REG_FRAMES  2'd3

`endif
